// File: verilog.f
rtl/riscv_isa_pkg.sv
rtl/branch_pred_pkg.sv
rtl/branch_engine.sv
rtl/btb.sv
rtl/bht.sv
rtl/branch_unit.sv
bench/tb_branch_unit.sv

// File: Bender.yml
package:
  name: branch_unit

dependencies: {}

sources:
  - rtl/riscv_isa_pkg.sv
  - rtl/branch_pred_pkg.sv
  - rtl/branch_engine.sv
  - rtl/btb.sv
  - rtl/bht.sv
  - rtl/branch_unit.sv
  - target: test
    files:
      - bench/tb_branch_unit.sv

// File: bench/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit;
    import riscv_isa_pkg::*;
    import branch_pred_pkg::*;

    localparam int unsigned NR_BTB_ENTRIES = 16;
    localparam int unsigned NR_BHT_ENTRIES = 64;
    localparam xlen_t ALL_ONES = {XLEN{1'b1}};
    localparam xlen_t SIGN_BIT = 64'h8000_0000_0000_0000;
    localparam xlen_t MAX_POS  = 64'h7fff_ffff_ffff_ffff;
    // pc used for training and invalidation, word aligned
    localparam xlen_t TRAIN_PC = 64'h0000_0000_8000_1000;

    logic       clk_i;
    logic       rst_i;
    xlen_t      fetch_pc_i;
    logic       predict_valid_o;
    logic       predict_taken_o;
    xlen_t      predict_address_o;
    branch_op_t operator_i;
    xlen_t      operand_a_i;
    xlen_t      operand_b_i;
    xlen_t      operand_c_i;
    xlen_t      imm_i;
    xlen_t      pc_i;
    logic       is_compressed_i;
    logic       fu_valid_i;
    logic       valid_i;
    logic       bp_valid_i;
    logic       bp_taken_i;
    xlen_t      bp_address_i;
    logic       res_valid_o;
    xlen_t      res_pc_o;
    xlen_t      res_target_o;
    logic       res_taken_o;
    logic       res_mispredict_o;
    logic       res_lower_16_o;
    logic       ex_valid_o;
    exc_cause_t ex_cause_o;
    xlen_t      ex_tval_o;

    logic [63:0] lcg_state;

    branch_unit #(
        .NR_BTB_ENTRIES (NR_BTB_ENTRIES),
        .NR_BHT_ENTRIES (NR_BHT_ENTRIES)
    ) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic xlen_t lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        // fold the high bits down, the low lcg bits have short periods
        return lcg_state ^ (lcg_state >> 33);
    endfunction

    // direction as the ISA defines each operator
    function automatic logic branch_taken(branch_op_t op, xlen_t a, xlen_t b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            GES:     return $signed(a) >= $signed(b);
            LTU:     return a < b;
            GEU:     return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // uncompressed instruction in the upper halfword is predicted on the next word
    function automatic xlen_t slot_pc(xlen_t pc, logic comp);
        if (!comp && pc[1]) begin
            return (pc | xlen_t'(3)) + xlen_t'(1);
        end
        return pc;
    endfunction

    function automatic logic mispredict(logic br_v, logic fu_v, xlen_t tgt, logic taken,
                                        logic bpv, logic bpt, xlen_t bpa);
        // a misaligned branch traps and never counts as a mispredict
        if (br_v) begin
            return !tgt[0] && (!bpv || bpt != taken || bpa != tgt);
        end
        return fu_v && bpv;
    endfunction

    function automatic bp_counter_t counter_step(bp_counter_t ctr, logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

    // operand pairs at the compare corners
    function automatic xlen_t boundary_operand(int idx, logic side_b);
        case (idx)
            0:       return xlen_t'(64'h1234);
            1:       return side_b ? xlen_t'(0) : SIGN_BIT;
            2:       return side_b ? SIGN_BIT : xlen_t'(0);
            3:       return side_b ? xlen_t'(0) : ALL_ONES;
            4:       return side_b ? ALL_ONES : xlen_t'(0);
            default: return side_b ? SIGN_BIT : MAX_POS;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_xlen(input string name, input xlen_t exp_val, input xlen_t act_val);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_t exp_val,
                               input exc_cause_t act_val);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
            stop_on_error();
        end
    endtask

    task automatic check_prediction(input logic exp_valid, input logic exp_taken,
                                    input xlen_t exp_addr);
        check_bit("predict_valid_o", exp_valid, predict_valid_o);
        check_bit("predict_taken_o", exp_taken, predict_taken_o);
        if (exp_valid) begin
            check_xlen("predict_address_o", exp_addr, predict_address_o);
        end
    endtask

    // one issue cycle, driven after the edge and checked at the falling edge
    task automatic resolve_and_check(input branch_op_t op, input xlen_t a, input xlen_t b,
            input xlen_t c, input xlen_t imm, input xlen_t pc, input logic comp,
            input logic fu_v, input logic br_v, input logic bpv, input logic bpt,
            input xlen_t bpa);
        xlen_t tgt;
        xlen_t fall;
        logic  taken;
        logic  miss;
        @(posedge clk_i);
        #2;
        operator_i      = op;
        operand_a_i     = a;
        operand_b_i     = b;
        operand_c_i     = c;
        imm_i           = imm;
        pc_i            = pc;
        is_compressed_i = comp;
        fu_valid_i      = fu_v;
        valid_i         = br_v;
        bp_valid_i      = bpv;
        bp_taken_i      = bpt;
        bp_address_i    = bpa;
        taken = branch_taken(op, a, b);
        tgt   = c + imm;
        fall  = pc + (comp ? xlen_t'(2) : xlen_t'(4));
        miss  = mispredict(br_v, fu_v, tgt, taken, bpv, bpt, bpa);
        @(negedge clk_i);
        check_bit("res_valid_o", br_v, res_valid_o);
        check_bit("res_mispredict_o", miss, res_mispredict_o);
        check_bit("ex_valid_o", br_v && tgt[0], ex_valid_o);
        check_xlen("res_pc_o", slot_pc(pc, comp), res_pc_o);
        check_bit("res_lower_16_o", comp ? !pc[1] : pc[1], res_lower_16_o);
        if (br_v) begin
            check_bit("res_taken_o", taken, res_taken_o);
        end
        // non-branch redirect goes back to the sequential path
        if (br_v || miss) begin
            check_xlen("res_target_o", (br_v && taken) ? tgt : fall, res_target_o);
        end
        if (br_v && tgt[0]) begin
            check_cause("ex_cause_o", INSTR_ADDR_MISALIGNED, ex_cause_o);
            check_xlen("ex_tval_o", pc, ex_tval_o);
        end
    endtask

    // idle issue cycles until the lookup reaches the wanted hit level
    task automatic wait_predict_valid(input logic level, input int max_cycles);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_i);
            #2;
            valid_i    = 1'b0;
            fu_valid_i = 1'b0;
            bp_valid_i = 1'b0;
            @(negedge clk_i);
            cycles++;
        end while (predict_valid_o !== level && cycles < max_cycles);
        if (predict_valid_o !== level) begin
            $display("timeout: predict_valid_o did not reach %b within %0d cycles",
                     level, max_cycles);
            stop_on_error();
        end
    endtask

    task automatic test_reset_miss();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            #2;
            fetch_pc_i = (i < 2) ? xlen_t'(i * 2) : (lcg_next() & ~xlen_t'(1));
            @(negedge clk_i);
            check_prediction(1'b0, 1'b0, '0);
        end
    endtask

    task automatic test_training();
        xlen_t       tgt;
        bp_counter_t ctr;
        tgt        = TRAIN_PC + 64'h40;
        ctr        = BP_COUNTER_RESET;
        @(posedge clk_i);
        #2;
        fetch_pc_i = TRAIN_PC;
        // taken jump with no prediction, the write is not bypassed
        resolve_and_check(JUMP, '0, '0, TRAIN_PC, 64'h40, TRAIN_PC, 1'b0, 1'b1, 1'b1,
                          1'b0, 1'b0, '0);
        check_prediction(1'b0, 1'b0, '0);
        ctr = counter_step(ctr, 1'b1);
        wait_predict_valid(1'b1, 1);
        check_prediction(1'b1, ctr >= 2, tgt);
        // unequal beq falls through and only trains the counter
        for (int i = 0; i < 2; i++) begin
            resolve_and_check(EQ, 64'd1, 64'd2, TRAIN_PC, 64'h40, TRAIN_PC, 1'b0, 1'b1, 1'b1,
                              1'b1, 1'b0, tgt);
            check_prediction(1'b1, ctr >= 2, tgt);
            ctr = counter_step(ctr, 1'b0);
        end
        wait_predict_valid(1'b1, 1);
        check_prediction(1'b1, ctr >= 2, tgt);
    endtask

    task automatic test_invalidate();
        @(posedge clk_i);
        #2;
        fetch_pc_i = TRAIN_PC;
        // fetch predicted a branch where there is none
        resolve_and_check(EQ, '0, '0, '0, '0, TRAIN_PC, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1,
                          TRAIN_PC + 64'h40);
        check_bit("predict_valid_o", 1'b1, predict_valid_o);
        wait_predict_valid(1'b0, 1);
    endtask

    task automatic test_compare();
        xlen_t a;
        xlen_t b;
        xlen_t r;
        for (int o = 0; o < 7; o++) begin
            for (int i = 0; i < 10; i++) begin
                a = (i < 6) ? boundary_operand(i, 1'b0) : lcg_next();
                b = (i < 6) ? boundary_operand(i, 1'b1) : ((i == 9) ? a : lcg_next());
                for (int comp = 0; comp < 2; comp++) begin
                    r = lcg_next();
                    // even base and offset keep the target aligned
                    resolve_and_check(branch_op_t'(o), a, b, r & ~xlen_t'(1),
                                      lcg_next() & ~xlen_t'(1), lcg_next() & ~xlen_t'(1),
                                      comp[0], 1'b1, 1'b1, r[8], r[9], r & ~xlen_t'(1));
                end
            end
        end
    endtask

    task automatic test_mispredict();
        xlen_t pc;
        xlen_t tgt;
        pc  = 64'h0000_0000_0040_2000;
        tgt = pc + 64'h100;
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, tgt);
        // wrong address
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1,
                          tgt + 64'h8);
        // wrong direction
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, tgt);
        // real branch that fetch never predicted
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, tgt);
        // correct not taken
        resolve_and_check(NE, 64'd5, 64'd5, pc, 64'h100, pc, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, tgt);
        // non-branch with and without a prediction
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, tgt);
        resolve_and_check(EQ, 64'd5, 64'd5, pc, 64'h100, pc, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, tgt);
    endtask

    task automatic test_misaligned();
        xlen_t pc;
        pc = 64'h0000_0000_0000_3006;
        resolve_and_check(JUMP, '0, '0, 64'h8000_0000, 64'h101, pc, 1'b0, 1'b1, 1'b1,
                          1'b0, 1'b0, '0);
        resolve_and_check(GEU, 64'd9, 64'd3, 64'h8000_0000, 64'h33, pc, 1'b1, 1'b1, 1'b1,
                          1'b1, 1'b1, 64'h8000_0033);
    endtask

    task automatic test_slot_rule();
        xlen_t pc;
        for (int i = 0; i < 3; i++) begin
            // last one wraps into the next word
            pc = (i == 0) ? 64'h1000 : ((i == 1) ? 64'h1002 : 64'h1ffe);
            for (int comp = 0; comp < 2; comp++) begin
                resolve_and_check(NE, 64'd7, 64'd7, pc, 64'h20, pc, comp[0], 1'b1, 1'b1,
                                  1'b0, 1'b0, '0);
            end
        end
    endtask

    initial begin
        lcg_state       = 64'd3910;
        rst_i           = 1'b1;
        fetch_pc_i      = '0;
        operator_i      = EQ;
        operand_a_i     = '0;
        operand_b_i     = '0;
        operand_c_i     = '0;
        imm_i           = '0;
        pc_i            = '0;
        is_compressed_i = 1'b0;
        fu_valid_i      = 1'b0;
        valid_i         = 1'b0;
        bp_valid_i      = 1'b0;
        bp_taken_i      = 1'b0;
        bp_address_i    = '0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        test_reset_miss();
        test_training();
        test_invalidate();
        test_compare();
        test_mispredict();
        test_misaligned();
        test_slot_rule();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit #(
    parameter int unsigned NR_BTB_ENTRIES = 16,
    parameter int unsigned NR_BHT_ENTRIES = 64
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // fetch side
    input  riscv_isa_pkg::xlen_t      fetch_pc_i,
    output logic                      predict_valid_o,
    output logic                      predict_taken_o,
    output riscv_isa_pkg::xlen_t      predict_address_o,
    // issue side
    input  riscv_isa_pkg::branch_op_t operator_i,
    input  riscv_isa_pkg::xlen_t      operand_a_i,
    input  riscv_isa_pkg::xlen_t      operand_b_i,
    input  riscv_isa_pkg::xlen_t      operand_c_i,
    input  riscv_isa_pkg::xlen_t      imm_i,
    input  riscv_isa_pkg::xlen_t      pc_i,
    input  logic                      is_compressed_i,
    input  logic                      fu_valid_i,
    input  logic                      valid_i,
    input  logic                      bp_valid_i,
    input  logic                      bp_taken_i,
    input  riscv_isa_pkg::xlen_t      bp_address_i,
    // resolution
    output logic                      res_valid_o,
    output riscv_isa_pkg::xlen_t      res_pc_o,
    output riscv_isa_pkg::xlen_t      res_target_o,
    output logic                      res_taken_o,
    output logic                      res_mispredict_o,
    output logic                      res_lower_16_o,
    output logic                      ex_valid_o,
    output riscv_isa_pkg::exc_cause_t ex_cause_o,
    output riscv_isa_pkg::xlen_t      ex_tval_o
);
    logic btb_hit;
    logic bht_taken;
    logic btb_update;
    logic btb_invalidate;
    logic bht_train;

    branch_engine u_branch_engine (
        .operator_i       (operator_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .operand_c_i      (operand_c_i),
        .imm_i            (imm_i),
        .pc_i             (pc_i),
        .is_compressed_i  (is_compressed_i),
        .fu_valid_i       (fu_valid_i),
        .valid_i          (valid_i),
        .bp_valid_i       (bp_valid_i),
        .bp_taken_i       (bp_taken_i),
        .bp_address_i     (bp_address_i),
        .res_valid_o      (res_valid_o),
        .res_pc_o         (res_pc_o),
        .res_target_o     (res_target_o),
        .res_taken_o      (res_taken_o),
        .res_mispredict_o (res_mispredict_o),
        .res_lower_16_o   (res_lower_16_o),
        .ex_valid_o       (ex_valid_o),
        .ex_cause_o       (ex_cause_o),
        .ex_tval_o        (ex_tval_o)
    );

    // only taken, non-trapping branches allocate a target
    assign btb_update     = res_valid_o && res_taken_o && !ex_valid_o;
    // a non-branch that hit in the table drops that entry
    assign btb_invalidate = res_mispredict_o && !res_valid_o;
    // every non-trapping branch trains its counter
    assign bht_train      = res_valid_o && !ex_valid_o;

    btb #(
        .NR_BTB_ENTRIES (NR_BTB_ENTRIES)
    ) u_btb (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .lookup_pc_i     (fetch_pc_i),
        .update_i        (btb_update),
        .update_pc_i     (res_pc_o),
        .update_target_i (res_target_o),
        .invalidate_i    (btb_invalidate),
        .hit_o           (btb_hit),
        .target_o        (predict_address_o)
    );

    bht #(
        .NR_BHT_ENTRIES (NR_BHT_ENTRIES)
    ) u_bht (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_pc_i   (fetch_pc_i),
        .train_pc_i    (res_pc_o),
        .train_i       (bht_train),
        .train_taken_i (res_taken_o),
        .taken_o       (bht_taken)
    );

    // direction only counts when the target buffer knows this pc
    assign predict_valid_o = btb_hit;
    assign predict_taken_o = btb_hit && bht_taken;

endmodule

// File: rtl/bht.sv
`timescale 1ns/1ps

module bht #(
    parameter int unsigned NR_BHT_ENTRIES = 64
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // fetch side lookup
    input  riscv_isa_pkg::xlen_t lookup_pc_i,
    // training from the resolved branch
    input  riscv_isa_pkg::xlen_t train_pc_i,
    input  logic                 train_i,
    input  logic                 train_taken_i,
    output logic                 taken_o
);
    import riscv_isa_pkg::*;
    import branch_pred_pkg::*;

    localparam int unsigned IDX_W = $clog2(NR_BHT_ENTRIES);

    typedef logic [IDX_W-1:0] bht_idx_t;

    bp_counter_t counter_q [NR_BHT_ENTRIES];
    bp_counter_t counter_cur;
    bp_counter_t counter_next;

    bht_idx_t lookup_idx;
    bht_idx_t train_idx;

    // untagged, halfword granular index
    assign lookup_idx = lookup_pc_i[IDX_W:1];
    assign train_idx  = train_pc_i[IDX_W:1];

    // upper bit of the counter is the predicted direction
    assign taken_o = counter_q[lookup_idx][1];

    assign counter_cur = counter_q[train_idx];

    // saturating step toward the resolved outcome
    always_comb begin
        counter_next = counter_cur;
        if (train_taken_i) begin
            if (counter_cur != BP_COUNTER_MAX) begin
                counter_next = counter_cur + bp_counter_t'(1);
            end
        end else if (counter_cur != BP_COUNTER_MIN) begin
            counter_next = counter_cur - bp_counter_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int unsigned i = 0; i < NR_BHT_ENTRIES; i++) begin
                counter_q[i] <= BP_COUNTER_RESET;
            end
        end else if (train_i) begin
            counter_q[train_idx] <= counter_next;
        end
    end

    // index math relies on a power-of-two entry count
    a_entries_pow2: assert property (@(posedge clk_i)
        NR_BHT_ENTRIES >= 2 && (NR_BHT_ENTRIES & (NR_BHT_ENTRIES - 1)) == 0)
        else $error("bht: NR_BHT_ENTRIES must be a power of two");

endmodule

// File: rtl/btb.sv
`timescale 1ns/1ps

module btb #(
    parameter int unsigned NR_BTB_ENTRIES = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // fetch side lookup
    input  riscv_isa_pkg::xlen_t lookup_pc_i,
    // training from the resolved branch
    input  logic                 update_i,
    input  riscv_isa_pkg::xlen_t update_pc_i,
    input  riscv_isa_pkg::xlen_t update_target_i,
    // drops the entry at update_pc_i
    input  logic                 invalidate_i,
    output logic                 hit_o,
    output riscv_isa_pkg::xlen_t target_o
);
    import riscv_isa_pkg::*;
    import branch_pred_pkg::*;

    localparam int unsigned IDX_W = $clog2(NR_BTB_ENTRIES);

    typedef logic [IDX_W-1:0] btb_idx_t;

    // entry storage, only the valid bits are control state
    logic [NR_BTB_ENTRIES-1:0] valid_q;
    bp_tag_t                   tag_q    [NR_BTB_ENTRIES];
    xlen_t                     target_q [NR_BTB_ENTRIES];

    btb_idx_t lookup_idx;
    btb_idx_t update_idx;
    bp_tag_t  lookup_tag;
    bp_tag_t  update_tag;

    // index starts at bit 1, halfword granularity
    assign lookup_idx = lookup_pc_i[IDX_W:1];
    assign update_idx = update_pc_i[IDX_W:1];
    // tag sits right above the index
    assign lookup_tag = lookup_pc_i[IDX_W+BP_TAG_WIDTH:IDX_W+1];
    assign update_tag = update_pc_i[IDX_W+BP_TAG_WIDTH:IDX_W+1];

    // same-cycle lookup
    // a write in this cycle is seen from the next cycle on
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[update_idx] <= 1'b1;
        end else if (invalidate_i) begin
            valid_q[update_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_target_i;
        end
    end

    // index math relies on a power-of-two entry count
    a_entries_pow2: assert property (@(posedge clk_i)
        NR_BTB_ENTRIES >= 2 && (NR_BTB_ENTRIES & (NR_BTB_ENTRIES - 1)) == 0)
        else $error("btb: NR_BTB_ENTRIES must be a power of two");

    // misaligned targets trap in execute and must never reach the table
    a_target_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        update_i |-> !update_target_i[0])
        else $error("btb: write of a misaligned target");

endmodule

// File: rtl/branch_engine.sv
`timescale 1ns/1ps

module branch_engine (
    input  riscv_isa_pkg::branch_op_t operator_i,
    input  riscv_isa_pkg::xlen_t      operand_a_i,
    input  riscv_isa_pkg::xlen_t      operand_b_i,
    input  riscv_isa_pkg::xlen_t      operand_c_i,
    input  riscv_isa_pkg::xlen_t      imm_i,
    input  riscv_isa_pkg::xlen_t      pc_i,
    input  logic                      is_compressed_i,
    // some functional unit issues this cycle
    input  logic                      fu_valid_i,
    // the issued instruction is a branch or jump
    input  logic                      valid_i,
    // prediction that travelled down the pipe with the instruction
    input  logic                      bp_valid_i,
    input  logic                      bp_taken_i,
    input  riscv_isa_pkg::xlen_t      bp_address_i,
    output logic                      res_valid_o,
    output riscv_isa_pkg::xlen_t      res_pc_o,
    output riscv_isa_pkg::xlen_t      res_target_o,
    output logic                      res_taken_o,
    output logic                      res_mispredict_o,
    output logic                      res_lower_16_o,
    output logic                      ex_valid_o,
    output riscv_isa_pkg::exc_cause_t ex_cause_o,
    output riscv_isa_pkg::xlen_t      ex_tval_o
);
    import riscv_isa_pkg::*;

    xlen_t          target_address;
    xlen_t          next_pc;
    logic           sgn;
    logic [XLEN:0]  ext_a;
    logic [XLEN:0]  ext_b;
    logic           less_than;
    logic           taken;

    // one compare path for signed and unsigned operators
    // the extra top bit carries the sign, cleared for LTU and GEU
    assign sgn   = !(operator_i inside {LTU, GEU});
    assign ext_a = {sgn & operand_a_i[XLEN-1], operand_a_i};
    assign ext_b = {sgn & operand_b_i[XLEN-1], operand_b_i};

    assign less_than = $signed(ext_a) < $signed(ext_b);

    always_comb begin
        // jumps fall into the default and are always taken
        case (operator_i)
            EQ:       taken = operand_a_i == operand_b_i;
            NE:       taken = operand_a_i != operand_b_i;
            LTS, LTU: taken = less_than;
            GES, GEU: taken = !less_than;
            default:  taken = 1'b1;
        endcase
    end

    // branch target, base register or pc plus immediate
    assign target_address = operand_c_i + imm_i;

    // fall-through depends on the instruction length
    assign next_pc = pc_i + (is_compressed_i ? xlen_t'(2) : xlen_t'(4));

    // slot pc for the prediction tables
    // an uncompressed branch that starts in the upper halfword spans two
    // fetch words, so its prediction sits on the following word
    // fetch then sees it on the word that completes the instruction
    assign res_pc_o = (is_compressed_i || !pc_i[1]) ? pc_i
                                                    : {pc_i[XLEN-1:2], 2'b00} + xlen_t'(4);

    // compressed in the low halfword, or uncompressed wrapping from the upper one
    assign res_lower_16_o = (is_compressed_i && !pc_i[1]) || (!is_compressed_i && pc_i[1]);

    assign res_valid_o = valid_i;
    assign res_taken_o = taken;

    always_comb begin
        res_mispredict_o = 1'b0;
        // taken goes to the target, not taken to the next instruction
        res_target_o     = taken ? target_address : next_pc;
        if (valid_i) begin
            // a misaligned target traps instead, no redirect from here
            if (!target_address[0]) begin
                // wrong address, wrong direction, or the branch was never predicted
                if (target_address != bp_address_i || bp_taken_i != taken || !bp_valid_i) begin
                    res_mispredict_o = 1'b1;
                end
            end
        end else if (fu_valid_i && bp_valid_i) begin
            // fetch thought this was a branch but it is not
            // redirect back onto the sequential path
            res_mispredict_o = 1'b1;
            res_target_o     = next_pc;
        end
    end

    // only a real branch may trap, tval reports the branch pc
    assign ex_valid_o = valid_i && target_address[0];
    assign ex_cause_o = INSTR_ADDR_MISALIGNED;
    assign ex_tval_o  = pc_i;

    // a trapping branch must never also redirect fetch
    always_comb begin
        assert final (!(ex_valid_o && res_mispredict_o))
            else $error("branch_engine: exception and mispredict raised together");
    end

endmodule

// File: rtl/branch_pred_pkg.sv
package branch_pred_pkg;

    // width of the tag kept per target buffer entry
    // taken from the pc bits directly above the index
    localparam int unsigned BP_TAG_WIDTH = 16;

    typedef logic [BP_TAG_WIDTH-1:0] bp_tag_t;

    // two-bit saturating counter of the history table
    // 0 strongly not taken, 1 weakly not taken
    // 2 weakly taken, 3 strongly taken
    typedef logic [1:0] bp_counter_t;

    // saturation limits
    localparam bp_counter_t BP_COUNTER_MIN = 2'd0;
    localparam bp_counter_t BP_COUNTER_MAX = 2'd3;

    // after reset every branch is weakly not taken
    // so a single taken resolution flips the prediction
    localparam bp_counter_t BP_COUNTER_RESET = 2'd1;

endpackage

// File: rtl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // data and address width of the core
    localparam int unsigned XLEN = 64;

    // every operand, pc and address in the branch path uses this width
    typedef logic [XLEN-1:0] xlen_t;

    // operator of the branch functional unit
    // the first six map onto the conditional branch funct3 cases
    // JUMP covers jal and jalr, which resolve as always taken
    typedef enum logic [2:0] {
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        JUMP
    } branch_op_t;

    // mcause exception code field
    typedef logic [5:0] exc_cause_t;

    // raised when a control transfer lands on an odd byte address
    // bit 1 may be set since compressed instructions are halfword aligned
    localparam exc_cause_t INSTR_ADDR_MISALIGNED = 6'd0;

endpackage
